// File: hdl/ddr_bridge_pkg.sv
/*
 * Widths, APB register map and control/status bit positions for the APB-to-Avalon bridge.
 * Avalon addresses are byte addresses and every transfer is a single beat.
 */
package ddr_bridge_pkg;

    // Avalon-MM master port widths
    localparam int ADDR_W  = 32;
    localparam int DATA_W  = 32;
    localparam int BE_W    = DATA_W / 8;
    localparam int BURST_W = 11;

    // The APB window only needs a handful of byte offsets
    localparam int PADDR_W = 8;

    // Shared data types for both sides of the bridge
    typedef logic [ADDR_W-1:0]  ddr_addr_t;
    typedef logic [DATA_W-1:0]  ddr_data_t;
    typedef logic [BE_W-1:0]    byte_en_t;
    typedef logic [PADDR_W-1:0] apb_addr_t;

    // APB register byte offsets
    localparam apb_addr_t REG_ADDR   = 8'h00;
    localparam apb_addr_t REG_WDATA  = 8'h04;
    localparam apb_addr_t REG_CTRL   = 8'h08;
    localparam apb_addr_t REG_STATUS = 8'h0C;
    localparam apb_addr_t REG_RDATA  = 8'h10;

    // Control word layout
    // Writing a 1 to go launches one command
    localparam int CTRL_GO     = 0;
    // Direction, 1 for write and 0 for read
    localparam int CTRL_WRITE  = 1;
    // Byte-enable field occupies control bits 7 to 4
    localparam int CTRL_BE_LSB = 4;

    // Status word layout
    localparam int STAT_BUSY    = 0;
    // Sticky, cleared once a status read has returned it
    localparam int STAT_DONE    = 1;
    // Direction of the most recently launched command
    localparam int STAT_LAST_WR = 2;

endpackage

// File: hdl/apb_cmd_regs.sv
/*
 * APB slave with pready tied high, so each transfer is one setup and one access cycle.
 * Only one command is in flight at a time. A go while busy is refused with pslverr.
 */
`timescale 1ns/10ps

module apb_cmd_regs
    import ddr_bridge_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    // APB slave port
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  ddr_data_t pwdata,
    output ddr_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    // Command side towards the Avalon master
    output logic      rd_en,
    output logic      wr_en,
    output ddr_addr_t sdram_address,
    output ddr_data_t write_data_input,
    output byte_en_t  byte_enable,
    // Results back from the Avalon master
    input  ddr_data_t read_data,
    input  logic      read_complete,
    input  logic      write_complete
);

    // Software-visible registers
    ddr_addr_t addr_reg;
    ddr_data_t wdata_reg;
    ddr_data_t ctrl_reg;
    logic      busy;
    logic      done;
    logic      last_wr;

    // Decoded APB transfer
    logic      access;
    logic      wr_access;
    logic      rd_access;
    logic      hit_addr;
    logic      hit_wdata;
    logic      hit_ctrl;
    logic      hit_status;
    logic      hit_rdata;
    logic      mapped;
    logic      go_req;
    logic      go_refused;
    logic      launch;
    logic      complete;
    ddr_data_t status_word;

    // A transfer only takes effect in its access phase
    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;

    // Offsets must match exactly, misaligned addresses count as unmapped
    assign hit_addr   = (paddr == REG_ADDR);
    assign hit_wdata  = (paddr == REG_WDATA);
    assign hit_ctrl   = (paddr == REG_CTRL);
    assign hit_status = (paddr == REG_STATUS);
    assign hit_rdata  = (paddr == REG_RDATA);
    assign mapped     = hit_addr || hit_wdata || hit_ctrl || hit_status || hit_rdata;

    // A go is accepted only when no command is outstanding
    assign go_req     = wr_access && hit_ctrl && pwdata[CTRL_GO];
    assign go_refused = go_req && busy;
    assign launch     = go_req && !busy;

    // The master pulses exactly one of these per command
    assign complete = read_complete || write_complete;

    // Zero wait states on this bus
    assign pready = 1'b1;

    // Errors for unmapped offsets, writes to read-only registers and a go while busy
    assign pslverr = access && (!mapped || (pwrite && (hit_status || hit_rdata)) || go_refused);

    // Command payload comes straight from the registers
    // The master captures it in the cycle that rd_en or wr_en is high
    assign sdram_address    = addr_reg;
    assign write_data_input = wdata_reg;
    assign byte_enable      = ctrl_reg[CTRL_BE_LSB +: BE_W];

    always_comb begin
        status_word               = '0;
        status_word[STAT_BUSY]    = busy;
        status_word[STAT_DONE]    = done;
        status_word[STAT_LAST_WR] = last_wr;
    end

    // Read mux, valid during the access phase since pready is always high
    always_comb begin
        case (paddr)
            REG_ADDR:   prdata = addr_reg;
            REG_WDATA:  prdata = wdata_reg;
            REG_CTRL:   prdata = ctrl_reg;
            REG_STATUS: prdata = status_word;
            REG_RDATA:  prdata = read_data;
            default:    prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            addr_reg  <= '0;
            wdata_reg <= '0;
            ctrl_reg  <= '0;
            busy      <= 1'b0;
            done      <= 1'b0;
            last_wr   <= 1'b0;
            rd_en     <= 1'b0;
            wr_en     <= 1'b0;
        end else begin
            // Enables are single-cycle pulses
            rd_en <= launch && !pwdata[CTRL_WRITE];
            wr_en <= launch && pwdata[CTRL_WRITE];

            if (wr_access && hit_addr) begin
                addr_reg <= pwdata;
            end
            if (wr_access && hit_wdata) begin
                wdata_reg <= pwdata;
            end
            // A refused go leaves the control word as it was
            if (wr_access && hit_ctrl && !go_refused) begin
                ctrl_reg <= pwdata;
            end

            // Launch and completion never coincide because launch needs busy low
            if (launch) begin
                busy    <= 1'b1;
                last_wr <= pwdata[CTRL_WRITE];
            end else if (complete) begin
                busy <= 1'b0;
            end

            // A new command clears done, a completion sets it,
            // and a status read clears it after returning the old value
            if (launch) begin
                done <= 1'b0;
            end else if (complete) begin
                done <= 1'b1;
            end else if (rd_access && hit_status) begin
                done <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/avalon_ddr3_interface.sv
/*
 * Single-beat Avalon-MM master, one outstanding transaction, burstcount fixed at one.
 * rd_en and wr_en are only honoured in the idle state. Write wins if both are high.
 */
`timescale 1ns/10ps

module avalon_ddr3_interface
    import ddr_bridge_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    // Avalon-MM master port
    output logic               avm_read,
    output logic               avm_write,
    output ddr_data_t          avm_writedata,
    output ddr_addr_t          avm_address,
    input  ddr_data_t          avm_readdata,
    input  logic               avm_readdatavalid,
    output byte_en_t           avm_byteenable,
    input  logic               avm_waitrequest,
    output logic [BURST_W-1:0] avm_burstcount,
    // Command from the register bank
    input  ddr_addr_t          sdram_address,
    input  logic               rd_en,
    input  logic               wr_en,
    input  ddr_data_t          write_data_input,
    input  byte_en_t           byte_enable,
    // Results back to the register bank
    output ddr_data_t          read_data,
    output logic               write_complete,
    output logic               read_complete
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_START,
        READ_START,
        READ_END
    } state_t;

    state_t state;
    state_t next_state;

    // Captured command, so the register bank can move on after one pulse
    ddr_addr_t addr_q;
    ddr_data_t data_q;
    byte_en_t  be_q;
    logic      capture;

    // Any enable seen while idle starts a command
    assign capture = (state == IDLE) && (rd_en || wr_en);

    // The command is presented for as long as the start state lasts,
    // which covers every waitrequest cycle and the accepting cycle
    assign avm_write      = (state == WRITE_START);
    assign avm_read       = (state == READ_START);
    assign avm_address    = addr_q;
    assign avm_writedata  = data_q;
    assign avm_byteenable = be_q;
    assign avm_burstcount = BURST_W'(1);

    // A write is finished as soon as the slave accepts it
    assign write_complete = (state == WRITE_START) && !avm_waitrequest;
    // A read is finished in the cycle its data comes back
    assign read_complete  = (state == READ_END) && avm_readdatavalid;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // Write has priority over read
                if (wr_en) begin
                    next_state = WRITE_START;
                end else if (rd_en) begin
                    next_state = READ_START;
                end
            end
            WRITE_START: begin
                // Stay until the slave drops waitrequest
                if (!avm_waitrequest) begin
                    next_state = IDLE;
                end
            end
            READ_START: begin
                // Once accepted, wait for the returning data
                if (!avm_waitrequest) begin
                    next_state = READ_END;
                end
            end
            READ_END: begin
                if (avm_readdatavalid) begin
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            read_data <= '0;
        end else begin
            state <= next_state;
            // Only readdatavalid in the read-end state belongs to our command
            if (read_complete) begin
                read_data <= avm_readdata;
            end
        end
    end

    // Payload holds steady from capture until the next command
    always_ff @(posedge clk) begin
        if (capture) begin
            addr_q <= sdram_address;
            data_q <= write_data_input;
            be_q   <= byte_enable;
        end
    end

endmodule

// File: hdl/ddr_bridge_top.sv
/*
 * APB register bank in front of a single-beat Avalon-MM master for a DDR3 controller port.
 */
`timescale 1ns/10ps

module ddr_bridge_top
    import ddr_bridge_pkg::*;
(
    input  logic               clk,
    input  logic               reset,
    // APB slave port
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  apb_addr_t          paddr,
    input  ddr_data_t          pwdata,
    output ddr_data_t          prdata,
    output logic               pready,
    output logic               pslverr,
    // Avalon-MM master port towards the DDR3 controller
    output logic               avm_read,
    output logic               avm_write,
    output ddr_addr_t          avm_address,
    output ddr_data_t          avm_writedata,
    output byte_en_t           avm_byteenable,
    output logic [BURST_W-1:0] avm_burstcount,
    input  ddr_data_t          avm_readdata,
    input  logic               avm_readdatavalid,
    input  logic               avm_waitrequest
);

    // Command and result wires between the two halves
    logic      rd_en;
    logic      wr_en;
    ddr_addr_t sdram_address;
    ddr_data_t write_data_input;
    byte_en_t  byte_enable;
    ddr_data_t read_data;
    logic      read_complete;
    logic      write_complete;

    apb_cmd_regs u_regs (
        .clk              (clk),
        .reset            (reset),
        .psel             (psel),
        .penable          (penable),
        .pwrite           (pwrite),
        .paddr            (paddr),
        .pwdata           (pwdata),
        .prdata           (prdata),
        .pready           (pready),
        .pslverr          (pslverr),
        .rd_en            (rd_en),
        .wr_en            (wr_en),
        .sdram_address    (sdram_address),
        .write_data_input (write_data_input),
        .byte_enable      (byte_enable),
        .read_data        (read_data),
        .read_complete    (read_complete),
        .write_complete   (write_complete)
    );

    avalon_ddr3_interface u_master (
        .clk               (clk),
        .reset             (reset),
        .avm_read          (avm_read),
        .avm_write         (avm_write),
        .avm_writedata     (avm_writedata),
        .avm_address       (avm_address),
        .avm_readdata      (avm_readdata),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_byteenable    (avm_byteenable),
        .avm_waitrequest   (avm_waitrequest),
        .avm_burstcount    (avm_burstcount),
        .sdram_address     (sdram_address),
        .rd_en             (rd_en),
        .wr_en             (wr_en),
        .write_data_input  (write_data_input),
        .byte_enable       (byte_enable),
        .read_data         (read_data),
        .write_complete    (write_complete),
        .read_complete     (read_complete)
    );

endmodule

// File: tests/ddr_bridge_asserts.sv
/*
 * Protocol checks on the Avalon-MM master port, bound into avalon_ddr3_interface.
 */
`timescale 1ns/10ps

module ddr_bridge_asserts
    import ddr_bridge_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      avm_read,
    input logic      avm_write,
    input logic      avm_waitrequest,
    input ddr_addr_t avm_address,
    input ddr_data_t avm_writedata,
    input byte_en_t  avm_byteenable
);

    // Failed checks so far, read by the testbench at the end of the run
    int failures = 0;

    // Only one direction may be requested at a time
    one_direction: assert property (@(posedge clk) disable iff (reset)
        !(avm_read && avm_write))
        else begin
            failures++;
            $error("Avalon read and write are high together");
        end

    // A stalled command keeps its request and payload until accepted
    hold_on_wait: assert property (@(posedge clk) disable iff (reset)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable({avm_read, avm_write, avm_address, avm_writedata, avm_byteenable}))
        else begin
            failures++;
            $error("Avalon command changed while waitrequest was high");
        end

    idle_after_reset: assert property (@(posedge clk) reset |=> !avm_read && !avm_write)
        else begin
            failures++;
            $error("Avalon read or write high in the cycle after reset");
        end

endmodule

bind avalon_ddr3_interface ddr_bridge_asserts u_asserts (
    .clk             (clk),
    .reset           (reset),
    .avm_read        (avm_read),
    .avm_write       (avm_write),
    .avm_waitrequest (avm_waitrequest),
    .avm_address     (avm_address),
    .avm_writedata   (avm_writedata),
    .avm_byteenable  (avm_byteenable)
);

// File: tests/ddr_bridge_tb.sv
/*
 * Random APB traffic through the bridge against an Avalon slave model with stalls and
 * read latency. The slave model decodes only address bits 9 to 2, so addresses alias.
 */
`timescale 1ns/10ps

module ddr_bridge_tb
    import ddr_bridge_pkg::*;
();

    localparam int NUM_TXN        = 200;
    // Ten APB accesses, eight stall cycles, four cycles of read latency and polling
    localparam int CYCLES_PER_TXN = 60;
    localparam int TIMEOUT_CYCLES = NUM_TXN * CYCLES_PER_TXN;
    localparam int POLL_LIMIT     = 64;
    localparam logic [31:0] SEED  = 32'h067c_c22a;

    logic clk, reset;
    logic psel, penable, pwrite, pready, pslverr;
    apb_addr_t paddr;
    ddr_data_t pwdata, prdata;
    logic avm_read, avm_write, avm_readdatavalid, avm_waitrequest;
    ddr_addr_t avm_address;
    ddr_data_t avm_writedata, avm_readdata;
    byte_en_t avm_byteenable;
    logic [BURST_W-1:0] avm_burstcount;

    // Slave memory stands in for the DDR3 device, the shadow copy is the reference
    ddr_data_t slave_mem [256];
    ddr_data_t shadow_mem [256];
    logic [31:0] stim_lfsr, slave_lfsr;
    int stall_left, read_wait, cycles = 0;
    logic in_cmd;
    logic [7:0] rd_idx;
    int data_errs = 0, status_errs = 0, err_errs = 0, burst_errs = 0, poll_fails = 0;

    ddr_bridge_top u_ddr_bridge_top (.*);

    always #4 clk = ~clk;

    // Taps 32, 22, 2 and 1 give a maximal-length sequence
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One step for every bit taken, first bit ends up most significant
    task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            st = lfsr_step(st);
            v  = {v[30:0], st[0]};
        end
    endtask

    // Every byte depends on the whole word index
    function automatic ddr_data_t fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, idx * 8'd13};
    endfunction

    function automatic ddr_data_t merge_bytes(input ddr_data_t old_w, input ddr_data_t new_w,
                                              input byte_en_t be);
        ddr_data_t res;
        res = old_w;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic ddr_data_t ctrl_word(input logic go, input logic wr, input byte_en_t be);
        ddr_data_t c;
        c = '0;
        c[CTRL_GO] = go;
        c[CTRL_WRITE] = wr;
        c[CTRL_BE_LSB +: BE_W] = be;
        return c;
    endfunction

    task automatic check_data(input string name, input ddr_data_t exp, input ddr_data_t act);
        if (act !== exp) begin
            data_errs++;
            $display("[ERROR] %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input logic [2:0] exp, input logic [2:0] act);
        if (act !== exp) begin
            status_errs++;
            $display("[ERROR] %s: expected %03b, actual %03b", name, exp, act);
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            err_errs++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_burst(input string name, input logic [BURST_W-1:0] exp,
                               input logic [BURST_W-1:0] act);
        if (act !== exp) begin
            burst_errs++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    // Starts and ends on a falling edge, outputs are sampled mid access phase
    task automatic apb_xfer(input logic wr, input apb_addr_t a, input ddr_data_t d,
                            output ddr_data_t rd, output logic err, output logic rdy);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = a;
        pwdata  = d;
        @(negedge clk);
        penable = 1'b1;
        #2;
        rd  = prdata;
        err = pslverr;
        rdy = pready;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input string name, input apb_addr_t a, input ddr_data_t d,
                             input logic exp_err);
        ddr_data_t rd;
        logic err;
        logic rdy;
        apb_xfer(1'b1, a, d, rd, err, rdy);
        check_err({name, " pslverr"}, exp_err, err);
        // Zero wait states, so every access phase completes at once
        check_err({name, " pready"}, 1'b1, rdy);
    endtask

    task automatic reg_read(input string name, input apb_addr_t a, input logic exp_err,
                            output ddr_data_t rd);
        logic err;
        logic rdy;
        apb_xfer(1'b0, a, '0, rd, err, rdy);
        check_err({name, " pslverr"}, exp_err, err);
        check_err({name, " pready"}, 1'b1, rdy);
    endtask

    task automatic poll_done(input string name, output logic [2:0] st);
        ddr_data_t rd;
        int n;
        n  = 0;
        st = '0;
        while (!st[STAT_DONE] && n < POLL_LIMIT) begin
            reg_read(name, REG_STATUS, 1'b0, rd);
            st = rd[2:0];
            n++;
        end
        if (!st[STAT_DONE]) begin
            poll_fails++;
            $display("%s: done bit still clear after %0d status reads", name, POLL_LIMIT);
        end
    endtask

    // Done must show with the direction, then clear after that read
    task automatic run_cmd(input string name, input logic wr, input byte_en_t be);
        logic [2:0] st;
        ddr_data_t rd;
        reg_write(name, REG_CTRL, ctrl_word(1'b1, wr, be), 1'b0);
        poll_done(name, st);
        check_status({name, " status"}, {wr, 1'b1, 1'b0}, st);
        reg_read(name, REG_STATUS, 1'b0, rd);
        check_status({name, " done cleared"}, {wr, 1'b0, 1'b0}, rd[2:0]);
    endtask

    task automatic do_write(input string name, input ddr_addr_t a, input ddr_data_t d,
                            input byte_en_t be);
        reg_write(name, REG_ADDR, a, 1'b0);
        reg_write(name, REG_WDATA, d, 1'b0);
        run_cmd({name, " write"}, 1'b1, be);
        shadow_mem[a[9:2]] = merge_bytes(shadow_mem[a[9:2]], d, be);
    endtask

    task automatic do_read(input string name, input ddr_addr_t a);
        ddr_data_t rd;
        reg_write(name, REG_ADDR, a, 1'b0);
        run_cmd({name, " read"}, 1'b0, 4'hf);
        reg_read(name, REG_RDATA, 1'b0, rd);
        check_data({name, " rdata"}, shadow_mem[a[9:2]], rd);
    endtask

    task automatic draw_addr(output ddr_addr_t a);
        draw_bits(stim_lfsr, 32, a);
        // Only 32 words are used so reads often revisit written data
        a[9:7] = 3'b000;
        a[1:0] = 2'b00;
    endtask

    // A second go lands while the first command is still in flight
    task automatic do_busy_go(input string name, input ddr_addr_t a);
        ddr_data_t d;
        ddr_data_t rd;
        logic [2:0] st;
        draw_bits(stim_lfsr, 32, d);
        reg_write(name, REG_ADDR, a, 1'b0);
        reg_write(name, REG_WDATA, d, 1'b0);
        reg_write({name, " read go"}, REG_CTRL, ctrl_word(1'b1, 1'b0, 4'hf), 1'b0);
        reg_write({name, " go while busy"}, REG_CTRL, ctrl_word(1'b1, 1'b1, 4'hf), 1'b1);
        poll_done(name, st);
        check_status({name, " status"}, 3'b010, st);
        reg_read(name, REG_CTRL, 1'b0, rd);
        check_data({name, " ctrl kept"}, ctrl_word(1'b1, 1'b0, 4'hf), rd);
        // Memory must still hold the old word
        do_read(name, a);
    endtask

    task automatic do_regs(input string name);
        ddr_data_t v;
        ddr_data_t rd;
        draw_bits(stim_lfsr, 32, v);
        reg_write(name, REG_ADDR, v, 1'b0);
        reg_read(name, REG_ADDR, 1'b0, rd);
        check_data({name, " addr readback"}, v, rd);
        draw_bits(stim_lfsr, 32, v);
        reg_write(name, REG_WDATA, v, 1'b0);
        reg_read(name, REG_WDATA, 1'b0, rd);
        check_data({name, " wdata readback"}, v, rd);
        draw_bits(stim_lfsr, 32, v);
        v[CTRL_GO] = 1'b0;
        reg_write(name, REG_CTRL, v, 1'b0);
        reg_read(name, REG_CTRL, 1'b0, rd);
        check_data({name, " ctrl readback"}, v, rd);
        reg_write({name, " status write"}, REG_STATUS, v, 1'b1);
        reg_write({name, " rdata write"}, REG_RDATA, v, 1'b1);
        // Offsets from 0x20 upwards decode to nothing
        reg_read({name, " unmapped"}, v[7:0] | 8'h20, 1'b1, rd);
    endtask

    // Avalon slave, decisions made on the falling edge take effect at the next rising edge
    always @(negedge clk) begin
        logic [31:0] r;
        avm_readdatavalid = 1'b0;
        if (reset) begin
            in_cmd          = 1'b0;
            read_wait       = 0;
            stall_left      = 0;
            avm_waitrequest = 1'b0;
        end else if (read_wait > 0) begin
            read_wait--;
            if (read_wait == 0) begin
                avm_readdatavalid = 1'b1;
                avm_readdata      = slave_mem[rd_idx];
            end
        end else if (avm_read || avm_write) begin
            if (!in_cmd) begin
                in_cmd = 1'b1;
                // Every command is a single beat
                check_burst("avalon burstcount", BURST_W'(1), avm_burstcount);
                draw_bits(slave_lfsr, 3, r);
                stall_left = int'(r);
            end
            if (stall_left > 0) begin
                avm_waitrequest = 1'b1;
                stall_left--;
            end else begin
                // Accepted at the next rising edge
                avm_waitrequest = 1'b0;
                in_cmd = 1'b0;
                if (avm_write) begin
                    slave_mem[avm_address[9:2]] = merge_bytes(slave_mem[avm_address[9:2]],
                                                              avm_writedata, avm_byteenable);
                end else begin
                    draw_bits(slave_lfsr, 2, r);
                    read_wait = int'(r) + 1;
                    rd_idx    = avm_address[9:2];
                end
            end
        end else begin
            avm_waitrequest = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        ddr_data_t rd;
        ddr_addr_t a;
        logic [31:0] r;
        int assert_fails;
        clk = 1'b0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        avm_readdata = '0;
        avm_readdatavalid = 1'b0;
        avm_waitrequest = 1'b0;
        stim_lfsr = SEED;
        slave_lfsr = SEED ^ 32'h5a5a_5a5a;
        for (int i = 0; i < 256; i++) begin
            slave_mem[i]  = fill_word(8'(i));
            shadow_mem[i] = fill_word(8'(i));
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        reg_read("reset status", REG_STATUS, 1'b0, rd);
        check_data("reset status", '0, rd);
        reg_read("reset rdata", REG_RDATA, 1'b0, rd);
        check_data("reset rdata", '0, rd);

        draw_addr(a);
        draw_bits(stim_lfsr, 32, r);
        do_write("full mask", a, r, 4'hf);
        do_read("full mask", a);

        for (int t = 0; t < NUM_TXN; t++) begin
            draw_bits(stim_lfsr, 2, r);
            draw_addr(a);
            case (r[1:0])
                2'd2: do_busy_go($sformatf("txn %0d busy go", t), a);
                2'd3: do_regs($sformatf("txn %0d regs", t));
                default: begin
                    draw_bits(stim_lfsr, 32, rd);
                    draw_bits(stim_lfsr, 4, r);
                    do_write($sformatf("txn %0d", t), a, rd, r[3:0]);
                    do_read($sformatf("txn %0d", t), a);
                end
            endcase
        end

        assert_fails = u_ddr_bridge_top.u_master.u_asserts.failures;
        $display("Errors: data %0d, status %0d, flag %0d, burst %0d, poll %0d, assertion %0d",
                 data_errs, status_errs, err_errs, burst_errs, poll_fails, assert_fails);
        if (data_errs + status_errs + err_errs + burst_errs + poll_fails + assert_fails == 0)
        begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: src.f
hdl/ddr_bridge_pkg.sv
hdl/apb_cmd_regs.sv
hdl/avalon_ddr3_interface.sv
hdl/ddr_bridge_top.sv
tests/ddr_bridge_asserts.sv
tests/ddr_bridge_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --timing --assert --timescale 1ns/10ps
TOP      := ddr_bridge_tb
FILELIST := src.f
OBJ_DIR  := obj_dir
PASS_MSG := Verification passed
RUN_OPTS := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_OPTS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
